//--- pix_pkg.sv
package pix_pkg;

    // ====================
    // Sizes
    // ====================

    // Pixels per frame, also words per image block
    localparam int pix_frame_words = 64;

    // Image blocks in on-chip memory
    localparam int pix_block_count = 4;

    // Depth of the pixel FIFO and the readout FIFO
    localparam int pix_fifo_depth = 8;

    // ====================
    // Payloads
    // ====================

    // Stored pixel, 12-bit sample with zero padding on top
    typedef logic [15:0] pix_word_t;

    // One readout beat
    typedef struct packed {
        pix_word_t word;
        logic      last;
    } pix_beat_t;

    // ====================
    // Commands
    // ====================

    // Opcode in CTRL bit 0
    localparam logic pix_cmd_capture = 1'b0;
    localparam logic pix_cmd_readout = 1'b1;

    // ====================
    // Register map
    // ====================

    // Word addresses on the Wishbone port
    localparam logic pix_reg_ctrl   = 1'b0;
    localparam logic pix_reg_status = 1'b1;

endpackage

//--- pix_fifo.sv
`timescale 1ns/1ps

module pix_fifo #(
    parameter type payload_t = pix_pkg::pix_word_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);
    import pix_pkg::*;

    localparam int ptr_w = $clog2(pix_fifo_depth);
    localparam int cnt_w = $clog2(pix_fifo_depth + 1);

    payload_t         mem [pix_fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(pix_fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == cnt_w'(pix_fifo_depth));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    // Head is visible as soon as it is written
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- pix_cmd_decode.sv
`timescale 1ns/1ps

module pix_cmd_decode (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    output logic        cmd_start,
    output logic        cmd_op,
    output logic [1:0]  cmd_block,
    input  logic        cmd_done,
    input  logic        overflow_set
);
    import pix_pkg::*;

    logic        access;
    logic        ctrl_wr;
    logic        launch;
    logic        busy;
    logic        overflow;
    logic [7:0]  done_count;
    logic [15:0] status;

    // New request only while no ack is pending
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_wr = access && wb_we && (wb_adr == pix_reg_ctrl);

    // STATUS layout: done count, overflow, busy
    assign status = {done_count, 6'b0, overflow, busy};

    // ====================
    // Bus handshake
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            if (wb_adr == pix_reg_status) begin
                wb_dat_r <= status;
            end else begin
                wb_dat_r <= {13'b0, cmd_block, cmd_op};
            end
        end
    end

    // ====================
    // Command launch
    // ====================
    // Accepted write sets busy at once, start pulse follows the ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            launch    <= 1'b0;
            cmd_start <= 1'b0;
            busy      <= 1'b0;
            cmd_op    <= pix_cmd_capture;
            cmd_block <= '0;
        end else begin
            cmd_start <= launch;
            launch    <= 1'b0;
            if (ctrl_wr && !busy) begin
                launch    <= 1'b1;
                busy      <= 1'b1;
                cmd_op    <= wb_dat_w[0];
                cmd_block <= wb_dat_w[2:1];
            end else if (cmd_done) begin
                busy <= 1'b0;
            end
        end
    end

    // ====================
    // Status counters
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_count <= '0;
            overflow   <= 1'b0;
        end else begin
            if (cmd_done) begin
                done_count <= done_count + 1'b1;
            end
            // A new overflow in the same cycle wins over the clear
            if (ctrl_wr) begin
                overflow <= 1'b0;
            end
            if (overflow_set) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- pix_capture.sv
`timescale 1ns/1ps

module pix_capture (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [11:0]        pix_d,
    input  logic               pix_fv,
    input  logic               pix_lv,
    input  logic               fifo_full,
    output logic               fifo_push,
    output pix_pkg::pix_word_t fifo_data,
    output logic               overflow_set
);
    import pix_pkg::*;

    localparam int cnt_w = $clog2(pix_frame_words);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_invalid,
        st_wait_start,
        st_capture
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] pix_cnt;
    logic             in_frame;
    logic             pix_seen;

    // First pixel may share the cycle with the rising fv
    assign in_frame = pix_fv && ((state == st_wait_start) || (state == st_capture));
    assign pix_seen = in_frame && pix_lv;

    assign fifo_push    = pix_seen && !fifo_full;
    assign fifo_data    = {4'b0, pix_d};
    assign overflow_set = pix_seen && fifo_full;

    // ====================
    // Frame sync
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            pix_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        pix_cnt <= '0;
                        state   <= st_wait_invalid;
                    end
                end
                // Skip any frame already in progress
                st_wait_invalid: begin
                    if (!pix_fv) begin
                        state <= st_wait_start;
                    end
                end
                st_wait_start: begin
                    if (pix_fv) begin
                        state <= st_capture;
                    end
                end
                st_capture: begin
                    if (!pix_fv) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            // Full frame pushed, stop early
            if (fifo_push) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == cnt_w'(pix_frame_words - 1)) begin
                    state <= st_idle;
                end
            end
        end
    end

endmodule

//--- pix_block_store.sv
`timescale 1ns/1ps

module pix_block_store (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_start,
    input  logic               cmd_op,
    input  logic [1:0]         cmd_block,
    output logic               cmd_done,
    input  logic               wr_empty,
    input  pix_pkg::pix_word_t wr_data,
    output logic               wr_pop,
    input  logic               rd_issue_ok,
    output logic               rd_valid,
    output pix_pkg::pix_word_t rd_data,
    output logic               rd_last,
    input  logic               beat_done
);
    import pix_pkg::*;

    localparam int word_w = $clog2(pix_frame_words);
    localparam int blk_w  = $clog2(pix_block_count);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read,
        st_drain
    } state_t;

    pix_word_t               mem [pix_block_count * pix_frame_words];
    state_t                  state;
    logic [blk_w-1:0]        block;
    logic [word_w-1:0]       word_cnt;
    logic [blk_w+word_w-1:0] addr;
    logic                    word_last;
    logic                    rd_issue;

    // Block base plus word offset
    assign addr      = {block, word_cnt};
    assign word_last = (word_cnt == word_w'(pix_frame_words - 1));

    assign wr_pop   = (state == st_write) && !wr_empty;
    assign rd_issue = (state == st_read) && rd_issue_ok;

    // ====================
    // Memory
    // ====================
    always_ff @(posedge clk) begin
        if (wr_pop) begin
            mem[addr] <= wr_data;
        end
        // One cycle read latency
        if (rd_issue) begin
            rd_data <= mem[addr];
            rd_last <= word_last;
        end
    end

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            block    <= '0;
            word_cnt <= '0;
            rd_valid <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            rd_valid <= rd_issue;
            if (wr_pop || rd_issue) begin
                word_cnt <= word_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (cmd_start) begin
                        block    <= cmd_block;
                        word_cnt <= '0;
                        state    <= (cmd_op == pix_cmd_readout) ? st_read : st_write;
                    end
                end
                st_write: begin
                    if (wr_pop && word_last) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_read: begin
                    if (rd_issue && word_last) begin
                        state <= st_drain;
                    end
                end
                // All reads issued, wait for the stream to finish
                st_drain: begin
                    if (beat_done) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- pix_readout.sv
`timescale 1ns/1ps

module pix_readout (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_valid,
    input  logic               rd_last,
    input  pix_pkg::pix_word_t rd_data,
    output logic               rd_issue_ok,
    output logic               beat_done,
    output logic               readout_valid,
    output logic               readout_last,
    output logic [15:0]        readout_data,
    input  logic               readout_ready
);
    import pix_pkg::*;

    localparam int lvl_w = $clog2(pix_fifo_depth + 1);

    pix_beat_t        in_beat;
    pix_beat_t        head;
    logic             empty;
    logic             pop;
    logic [lvl_w-1:0] level;

    assign in_beat = '{word: rd_data, last: rd_last};

    // Output buffer, reads land here one cycle after issue
    pix_fifo #(
        .payload_t(pix_beat_t)
    ) u_beat_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rd_valid),
        .push_data(in_beat),
        .full     (),
        .pop      (pop),
        .pop_data (head),
        .empty    (empty)
    );

    // Stream straight from the FIFO head
    assign readout_valid = !empty;
    assign readout_data  = head.word;
    assign readout_last  = head.last;
    assign pop           = readout_valid && readout_ready;
    assign beat_done     = pop && head.last;

    // Room must cover the read already in flight
    assign rd_issue_ok = (level + lvl_w'(rd_valid)) < lvl_w'(pix_fifo_depth);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            case ({rd_valid, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

//--- pix_controller.sv
`timescale 1ns/1ps

module pix_controller (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    input  logic [11:0] pix_d,
    input  logic        pix_fv,
    input  logic        pix_lv,
    output logic        readout_valid,
    output logic [15:0] readout_data,
    output logic        readout_last,
    input  logic        readout_ready
);
    import pix_pkg::*;

    logic       cmd_start;
    logic       cmd_op;
    logic [1:0] cmd_block;
    logic       cmd_done;
    logic       overflow_set;
    logic       capture_start;
    logic       px_push;
    pix_word_t  px_push_data;
    logic       px_full;
    logic       px_pop;
    pix_word_t  px_pop_data;
    logic       px_empty;
    logic       rd_issue_ok;
    logic       rd_valid;
    pix_word_t  rd_data;
    logic       rd_last;
    logic       beat_done;

    assign capture_start = cmd_start && (cmd_op == pix_cmd_capture);

    // ====================
    // Decode
    // ====================
    pix_cmd_decode u_cmd_decode (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cmd_start(cmd_start), .cmd_op(cmd_op), .cmd_block(cmd_block),
        .cmd_done(cmd_done), .overflow_set(overflow_set)
    );

    // ====================
    // Execute
    // ====================
    pix_capture u_capture (
        .clk(clk), .rst_n(rst_n), .start(capture_start),
        .pix_d(pix_d), .pix_fv(pix_fv), .pix_lv(pix_lv),
        .fifo_full(px_full), .fifo_push(px_push), .fifo_data(px_push_data),
        .overflow_set(overflow_set)
    );

    // Sensor side to memory side
    pix_fifo #(
        .payload_t(pix_word_t)
    ) u_pixel_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(px_push), .push_data(px_push_data), .full(px_full),
        .pop(px_pop), .pop_data(px_pop_data), .empty(px_empty)
    );

    pix_block_store u_block_store (
        .clk(clk), .rst_n(rst_n),
        .cmd_start(cmd_start), .cmd_op(cmd_op), .cmd_block(cmd_block), .cmd_done(cmd_done),
        .wr_empty(px_empty), .wr_data(px_pop_data), .wr_pop(px_pop),
        .rd_issue_ok(rd_issue_ok), .rd_valid(rd_valid), .rd_data(rd_data),
        .rd_last(rd_last), .beat_done(beat_done)
    );

    // ====================
    // Result
    // ====================
    pix_readout u_readout (
        .clk(clk), .rst_n(rst_n),
        .rd_valid(rd_valid), .rd_last(rd_last), .rd_data(rd_data),
        .rd_issue_ok(rd_issue_ok), .beat_done(beat_done),
        .readout_valid(readout_valid), .readout_last(readout_last),
        .readout_data(readout_data), .readout_ready(readout_ready)
    );

endmodule

//--- tb_pix_controller.sv
`timescale 1ns/1ps

module tb_pix_controller;
    import pix_pkg::*;

    localparam int clk_period   = 8;
    localparam int frame_lines  = 8;
    localparam int line_pixels  = 8;
    localparam int line_gap     = 4;
    localparam int frame_cycles = 4 + frame_lines * (line_pixels + line_gap) + 16;
    localparam int test_count   = 6;
    localparam int timeout_ns   = 4 * frame_cycles * test_count * clk_period;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic [11:0] pix_d;
    logic        pix_fv;
    logic        pix_lv;
    logic        readout_valid;
    logic [15:0] readout_data;
    logic        readout_last;
    logic        readout_ready;

    integer      seed = 65379;
    int          errors = 0;
    int          checks = 0;
    logic [7:0]  exp_done = '0;

    // Last frame sent by the sensor model, and stored blocks
    logic [11:0] frame_pix [pix_frame_words];
    pix_word_t   sb [pix_block_count][pix_frame_words];

    pix_controller u_pix_controller (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .pix_d(pix_d), .pix_fv(pix_fv), .pix_lv(pix_lv),
        .readout_valid(readout_valid), .readout_data(readout_data),
        .readout_last(readout_last), .readout_ready(readout_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ====================
    // Protocol checks
    // ====================
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else begin
        errors++;
        $display("Fail %0t: request not acknowledged in the next cycle", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
        errors++;
        $display("Fail %0t: ack held longer than one cycle", $time);
    end

    // Stalled beat must hold
    assert property (@(posedge clk) disable iff (!rst_n)
        (readout_valid && !readout_ready) |=>
        (readout_valid && $stable(readout_data) && $stable(readout_last)))
    else begin
        errors++;
        $display("Fail %0t: stalled readout beat changed", $time);
    end

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    function automatic logic [15:0] ctrl_word(input logic op, input logic [1:0] blk);
        return {13'b0, blk, op};
    endfunction

    // ====================
    // Bus tasks
    // ====================
    task automatic bus_access(input logic we, input logic adr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waited < 16) begin
            waited++;
            @(negedge clk);
        end
        check(waited == 1, $sformatf("ack came %0d cycles after the request", waited));
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic adr, input logic [15:0] wdata);
        logic [15:0] unused;
        bus_access(1'b1, adr, wdata, unused);
    endtask

    task automatic bus_read(input logic adr, output logic [15:0] rdata);
        bus_access(1'b0, adr, 16'h0, rdata);
    endtask

    // Poll until idle, then expect one more completed command
    task automatic finish_command();
        logic [15:0] st;
        int          polls;
        polls = 0;
        bus_read(pix_reg_status, st);
        while (st[0] && polls < 300) begin
            polls++;
            bus_read(pix_reg_status, st);
        end
        if (st[0]) begin
            errors++;
            $display("Command still busy after %0d status polls", polls);
        end
        exp_done++;
        check(st[15:8] == exp_done,
              $sformatf("done count %0d, expected %0d", st[15:8], exp_done));
    endtask

    // ====================
    // Sensor model
    // ====================
    task automatic send_frame(input int lines);
        int n;
        int l;
        int p;
        int rnd;
        n = 0;
        repeat (4) begin
            @(posedge clk);
            pix_fv <= 1'b0;
            pix_lv <= 1'b0;
        end
        for (l = 0; l < lines; l++) begin
            for (p = 0; p < line_pixels; p++) begin
                @(posedge clk);
                rnd = $random(seed);
                pix_d  <= rnd[11:0];
                pix_fv <= 1'b1;
                pix_lv <= 1'b1;
                if (n < pix_frame_words) begin
                    frame_pix[n] = rnd[11:0];
                end
                n++;
            end
            // Line blanking, frame still valid
            repeat (line_gap) begin
                @(posedge clk);
                pix_lv <= 1'b0;
                pix_d  <= '0;
            end
        end
        @(posedge clk);
        pix_fv <= 1'b0;
    endtask

    task automatic store_frame(input int blk);
        for (int i = 0; i < pix_frame_words; i++) begin
            sb[blk][i] = {4'h0, frame_pix[i]};
        end
    endtask

    // ====================
    // Readout sink
    // ====================
    task automatic stream_block(input int blk, input logic random_ready);
        int idx;
        int cycles;
        int rnd;
        idx = 0;
        cycles = 0;
        while (idx < pix_frame_words && cycles < 1000) begin
            @(negedge clk);
            cycles++;
            if (readout_valid && readout_ready) begin
                check(readout_data == sb[blk][idx],
                      $sformatf("block %0d beat %0d data %h, expected %h",
                                blk, idx, readout_data, sb[blk][idx]));
                check(readout_last == (idx == pix_frame_words - 1),
                      $sformatf("block %0d beat %0d last flag %b", blk, idx, readout_last));
                idx++;
            end
            @(posedge clk);
            rnd = $random(seed);
            readout_ready <= random_ready ? rnd[0] : 1'b1;
        end
        readout_ready <= 1'b0;
        if (idx < pix_frame_words) begin
            errors++;
            $display("Readout of block %0d stopped after %0d beats", blk, idx);
        end
        @(negedge clk);
        check(!readout_valid, $sformatf("extra beat after block %0d", blk));
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: simulation still running after %0d ns", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [15:0] st;
        rst_n         = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = 1'b0;
        wb_dat_w      = '0;
        pix_d         = '0;
        pix_fv        = 1'b0;
        pix_lv        = 1'b0;
        readout_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Idle status after reset
        bus_read(pix_reg_status, st);
        check(st == 16'h0, $sformatf("STATUS after reset %h", st));

        // Capture and read back block 1
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd1));
        send_frame(frame_lines);
        store_frame(1);
        finish_command();
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_readout, 2'd1));
        stream_block(1, 1'b0);
        finish_command();

        // Capture issued mid-frame takes the next frame
        fork
            send_frame(frame_lines);
            begin
                repeat (30) @(posedge clk);
                bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd0));
            end
        join
        send_frame(frame_lines);
        store_frame(0);
        finish_command();
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd2));
        send_frame(frame_lines);
        store_frame(2);
        finish_command();
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_readout, 2'd2));
        stream_block(2, 1'b0);
        finish_command();

        // Stalled readout, CTRL write while busy, random back-pressure
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_readout, 2'd0));
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd3));
        bus_read(pix_reg_status, st);
        check(st[0] == 1'b1, "busy low during a stalled readout");
        check(st[15:8] == exp_done, $sformatf("done count %0d while busy", st[15:8]));
        stream_block(0, 1'b1);
        finish_command();
        repeat (16) @(posedge clk);
        bus_read(pix_reg_status, st);
        check(st == {exp_done, 8'h00}, $sformatf("ignored write left STATUS %h", st));
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_readout, 2'd1));
        stream_block(1, 1'b1);
        finish_command();

        // Pixel FIFO held full through a long frame
        force u_pix_controller.px_full = 1'b1;
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd3));
        send_frame(12);
        bus_read(pix_reg_status, st);
        check(st[1] == 1'b1, "overflow flag not set");
        check(st[0] == 1'b1, "busy low during a stuck capture");
        release u_pix_controller.px_full;
        bus_write(pix_reg_ctrl, ctrl_word(pix_cmd_capture, 2'd0));
        bus_read(pix_reg_status, st);
        check(st[1] == 1'b0, "overflow flag not cleared by CTRL write");
        check(st[15:8] == exp_done, $sformatf("done count %0d after overflow", st[15:8]));

        $display("Run complete: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
pix_pkg.sv
pix_fifo.sv
pix_cmd_decode.sv
pix_capture.sv
pix_block_store.sv
pix_readout.sv
pix_controller.sv
tb_pix_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pix_controller -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }
